//--- sim.f
soc_mem_pkg.sv
obi_if.sv
wb_obi_bridge.sv
host_addr_remap.sv
obi_arbiter.sv
sram_bank.sv
soc_mem_top.sv
soc_mem_sva.sv
tb_clk_gen.sv
tb_soc_mem.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_soc_mem -f sim.f -o sim_tb > build.log 2>&1; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if ! grep -q "TEST PASS" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0

//--- tb_soc_mem.sv
`timescale 1ns/1ps

module tb_soc_mem import soc_mem_pkg::*; ();

    localparam int unsigned SRAM_DEPTH      = 256;
    localparam int unsigned MAX_OUTSTANDING = 4;
    localparam int          TIMEOUT         = 200;
    localparam int          N_CORE          = 32;
    localparam int          N_HOST          = 8;

    logic      clk;
    logic      rst_n;
    logic      wbs_cyc_i;
    logic      wbs_stb_i;
    logic      wbs_we_i;
    obi_be_t   wbs_sel_i;
    obi_addr_t wbs_adr_i;
    obi_data_t wbs_dat_i;
    logic      wbs_ack_o;
    obi_data_t wbs_dat_o;
    logic      core_req_i;
    obi_addr_t core_addr_i;
    logic      core_we_i;
    obi_be_t   core_be_i;
    obi_data_t core_wdata_i;
    logic      core_gnt_o;
    logic      core_rvalid_o;
    obi_data_t core_rdata_o;
    logic      host_en_i;
    logic      illegal_access_o;

    // Reference memory and expected responses per port
    obi_data_t ref_mem [SRAM_DEPTH];
    obi_data_t host_exp_data [$];
    logic      host_exp_ill [$];
    obi_data_t core_exp_data [$];
    logic      core_exp_ill [$];
    logic      host_hold;
    logic      illegal_prev;
    integer    seed;

    // Pregenerated random traffic
    obi_addr_t rc_addr [N_CORE];
    logic      rc_we [N_CORE];
    obi_be_t   rc_be [N_CORE];
    obi_data_t rc_wdata [N_CORE];
    obi_addr_t rh_addr [N_HOST];
    logic      rh_we [N_HOST];
    obi_be_t   rh_be [N_HOST];
    obi_data_t rh_wdata [N_HOST];

    tb_clk_gen #(
        .PERIOD_NS  (10.0),
        .RST_CYCLES (16)
    ) u_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    soc_mem_top #(
        .SRAM_DEPTH      (SRAM_DEPTH),
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) UUT (
        .clk_i            (clk),
        .rst_n_i          (rst_n),
        .wbs_cyc_i        (wbs_cyc_i),
        .wbs_stb_i        (wbs_stb_i),
        .wbs_we_i         (wbs_we_i),
        .wbs_sel_i        (wbs_sel_i),
        .wbs_adr_i        (wbs_adr_i),
        .wbs_dat_i        (wbs_dat_i),
        .wbs_ack_o        (wbs_ack_o),
        .wbs_dat_o        (wbs_dat_o),
        .core_req_i       (core_req_i),
        .core_addr_i      (core_addr_i),
        .core_we_i        (core_we_i),
        .core_be_i        (core_be_i),
        .core_wdata_i     (core_wdata_i),
        .core_gnt_o       (core_gnt_o),
        .core_rvalid_o    (core_rvalid_o),
        .core_rdata_o     (core_rdata_o),
        .host_en_i        (host_en_i),
        .illegal_access_o (illegal_access_o)
    );

    bind obi_arbiter soc_mem_sva u_arb_sva (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .host_en_i     (host_en_i),
        .queue_empty_i (count_q == '0),
        .mem_rvalid_i  (mem.rvalid),
        .host_req_i    (host.req),
        .host_gnt_i    (host.gnt),
        .host_rvalid_i (host.rvalid),
        .host_fields_i ({host.addr, host.we, host.be, host.wdata}),
        .core_req_i    (core.req),
        .core_gnt_i    (core.gnt),
        .core_fields_i ({core.addr, core.we, core.be, core.wdata})
    );

    ////////////////////////////////////////////////////////////
    // Error handling and compare tasks
    ////////////////////////////////////////////////////////////

    task automatic stop_on_error();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_failure(input string what);
        $display("ERROR: %s", what);
        stop_on_error();
    endtask

    task automatic check_data(input string name, input obi_data_t got, input obi_data_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    // Remap for host traffic, then decode, merge bytes, read
    function automatic obi_data_t ref_access(input logic from_host, input obi_addr_t addr,
                                             input logic we, input obi_be_t be,
                                             input obi_data_t wdata, output logic illegal);
        obi_addr_t   a;
        int unsigned idx;
        obi_data_t   rd;
        a = addr;
        if (from_host && addr >= HOST_WIN_LO && addr < HOST_WIN_HI) begin
            a = {SRAM_BASE[31:28], addr[27:0]};
        end
        idx     = (a & ~REGION_MASK) >> 2;
        illegal = ((a & REGION_MASK) != SRAM_BASE) || (idx >= SRAM_DEPTH);
        rd      = '0;
        if (!illegal && we) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    ref_mem[idx][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end else if (!illegal) begin
            rd = ref_mem[idx];
        end
        return rd;
    endfunction

    ////////////////////////////////////////////////////////////
    // Stimulus tasks, entered on a falling edge
    ////////////////////////////////////////////////////////////

    task automatic wait_reset_done();
        int cycles;
        cycles = 0;
        while (!rst_n) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure("reset was never released");
            end
        end
        @(negedge clk);
        check_flag("wbs_ack_o", wbs_ack_o, 1'b0);
        check_flag("core_gnt_o", core_gnt_o, 1'b0);
        check_flag("core_rvalid_o", core_rvalid_o, 1'b0);
        check_flag("illegal_access_o", illegal_access_o, 1'b0);
    endtask

    task automatic host_start(input logic we, input obi_addr_t addr, input obi_be_t sel,
                              input obi_data_t data);
        logic      ill;
        obi_data_t exp;
        exp = ref_access(1'b1, addr, we, sel, data, ill);
        host_exp_data.push_back(exp);
        host_exp_ill.push_back(ill);
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        wbs_we_i  = we;
        wbs_sel_i = sel;
        wbs_adr_i = addr;
        wbs_dat_i = data;
    endtask

    task automatic host_wait_ack();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure("no Wishbone acknowledge within the timeout");
            end
        end while (!wbs_ack_o);
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
    endtask

    task automatic host_access(input logic we, input obi_addr_t addr, input obi_be_t sel,
                               input obi_data_t data);
        host_start(we, addr, sel, data);
        host_wait_ack();
    endtask

    // Model updates at grant, the point where the SRAM orders accesses
    task automatic core_issue(input logic we, input obi_addr_t addr, input obi_be_t be,
                              input obi_data_t data);
        int        cycles;
        logic      ill;
        obi_data_t exp;
        core_req_i   = 1'b1;
        core_we_i    = we;
        core_addr_i  = addr;
        core_be_i    = be;
        core_wdata_i = data;
        cycles       = 0;
        #1;
        while (!core_gnt_o) begin
            @(negedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure("core request was never granted");
            end
        end
        exp = ref_access(1'b0, addr, we, be, data, ill);
        core_exp_data.push_back(exp);
        core_exp_ill.push_back(ill);
        @(negedge clk);
        core_req_i = 1'b0;
    endtask

    task automatic wait_core_idle();
        int cycles;
        cycles = 0;
        while (core_exp_data.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                report_failure("core responses missing after the timeout");
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Response compare
    ////////////////////////////////////////////////////////////

    // Host ack trails the memory response by one cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (core_rvalid_o) begin
                if (core_exp_data.size() == 0) begin
                    report_failure("core response without an outstanding request");
                end else begin
                    check_data("core_rdata_o", core_rdata_o, core_exp_data.pop_front());
                    check_flag("illegal_access_o", illegal_access_o, core_exp_ill.pop_front());
                end
            end
            if (wbs_ack_o) begin
                if (host_hold) begin
                    report_failure("wbs_ack_o arrived while host_en_i was low");
                end else if (host_exp_data.size() == 0) begin
                    report_failure("Wishbone acknowledge without an open cycle");
                end else begin
                    check_data("wbs_dat_o", wbs_dat_o, host_exp_data.pop_front());
                    check_flag("illegal_access_o", illegal_prev, host_exp_ill.pop_front());
                end
            end
            illegal_prev = illegal_access_o;
        end
    end

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int        i;
        obi_addr_t a;
        obi_data_t r;
        seed         = 79;
        host_hold    = 1'b0;
        illegal_prev = 1'b0;
        wbs_cyc_i    = 1'b0;
        wbs_stb_i    = 1'b0;
        wbs_we_i     = 1'b0;
        wbs_sel_i    = '0;
        wbs_adr_i    = '0;
        wbs_dat_i    = '0;
        core_req_i   = 1'b0;
        core_addr_i  = '0;
        core_we_i    = 1'b0;
        core_be_i    = '0;
        core_wdata_i = '0;
        host_en_i    = 1'b1;
        wait_reset_done();

        // Fill pattern over the whole address
        for (i = 0; i < int'(SRAM_DEPTH); i++) begin
            a = SRAM_BASE + 32'(i * 4);
            core_issue(1'b1, a, 4'hF, {a[15:0], a[31:16]} ^ ~a);
        end
        wait_core_idle();

        // Host write and read back, core sees the same word
        host_access(1'b1, 32'h3000_0010, 4'hF, 32'hCAFE_0123);
        host_access(1'b0, 32'h3000_0010, 4'hF, '0);
        core_issue(1'b0, 32'h8000_0010, 4'hF, '0);
        wait_core_idle();

        // Partial writes
        core_issue(1'b1, 32'h8000_0020, 4'hF, 32'h1122_3344);
        core_issue(1'b1, 32'h8000_0020, 4'b0001, 32'hAAAA_AAEE);
        core_issue(1'b1, 32'h8000_0020, 4'b0110, 32'hBBCC_DDFF);
        core_issue(1'b1, 32'h8000_0020, 4'b1000, 32'h99FF_FFFF);
        core_issue(1'b0, 32'h8000_0020, 4'hF, '0);
        wait_core_idle();

        // Core write seen by the host through another window region
        core_issue(1'b1, 32'h8000_0044, 4'hF, 32'h5EED_F00D);
        wait_core_idle();
        host_access(1'b0, 32'h6000_0044, 4'hF, '0);

        // Illegal accesses, index SRAM_DEPTH would alias word 0
        core_issue(1'b1, 32'h9000_0000, 4'hF, 32'hDEAD_BEEF);
        core_issue(1'b1, SRAM_BASE + 32'(SRAM_DEPTH * 4), 4'hF, 32'hDEAD_BEEF);
        core_issue(1'b0, SRAM_BASE + 32'(SRAM_DEPTH * 4), 4'hF, '0);
        core_issue(1'b0, 32'h9000_0000, 4'hF, '0);
        wait_core_idle();
        host_access(1'b1, 32'h9000_0000, 4'hF, 32'h0BAD_0BAD);
        host_access(1'b0, 32'h2000_0000, 4'hF, '0);
        core_issue(1'b0, SRAM_BASE, 4'hF, '0);
        wait_core_idle();

        // Host blocked by host_en_i, core keeps going
        host_hold = 1'b1;
        host_en_i = 1'b0;
        host_start(1'b0, 32'h3000_0010, 4'hF, '0);
        for (i = 0; i < 4; i++) begin
            core_issue(i[0], 32'h8000_0100 + 32'(i * 4), 4'hF, 32'h7700_0000 + 32'(i));
        end
        wait_core_idle();
        repeat (50) @(negedge clk);
        host_hold = 1'b0;
        host_en_i = 1'b1;
        host_wait_ack();

        // Random traffic, host and core on disjoint words
        for (i = 0; i < N_CORE; i++) begin
            r           = $random(seed);
            rc_we[i]    = r[0];
            rc_be[i]    = r[4:1];
            rc_addr[i]  = SRAM_BASE | obi_addr_t'({1'b1, r[10:5], 2'b00});
            rc_wdata[i] = $random(seed);
        end
        for (i = 0; i < N_HOST; i++) begin
            r           = $random(seed);
            rh_we[i]    = r[0];
            rh_be[i]    = r[4:1];
            rh_addr[i]  = (obi_addr_t'(3 + r[7:5] % 5) << 28) | obi_addr_t'({r[13:8], 2'b00});
            rh_wdata[i] = $random(seed);
        end
        fork
            begin
                for (int k = 0; k < N_CORE; k++) begin
                    core_issue(rc_we[k], rc_addr[k], rc_be[k], rc_wdata[k]);
                end
            end
            begin
                for (int k = 0; k < N_HOST; k++) begin
                    host_access(rh_we[k], rh_addr[k], rh_be[k], rh_wdata[k]);
                end
            end
        join
        wait_core_idle();

        repeat (5) @(negedge clk);
        if (host_exp_data.size() != 0 || core_exp_data.size() != 0) begin
            report_failure("responses still missing at the end of the run");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS  = 10.0,
    parameter int  RST_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    // Release on a falling edge, clear of the DUT sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

//--- soc_mem_sva.sv
`timescale 1ns/1ps

module soc_mem_sva (
    input logic        clk_i,
    input logic        rst_n_i,
    input logic        host_en_i,
    input logic        queue_empty_i,
    input logic        mem_rvalid_i,
    input logic        host_req_i,
    input logic        host_gnt_i,
    input logic        host_rvalid_i,
    input logic [68:0] host_fields_i,
    input logic        core_req_i,
    input logic        core_gnt_i,
    input logic [68:0] core_fields_i
);

    // A response needs a recorded owner
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_rvalid_i |-> !queue_empty_i)
        else $error("rvalid from memory while the owner queue is empty");

    // The SRAM answers one cycle after the grant
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !host_en_i |=> !host_rvalid_i)
        else $error("host response for a transfer granted while host_en_i was low");

    // Pending requests hold until granted
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        host_req_i && !host_gnt_i |=> host_req_i && $stable(host_fields_i))
        else $error("host request changed before grant");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        core_req_i && !core_gnt_i |=> core_req_i && $stable(core_fields_i))
        else $error("core request changed before grant");

endmodule

//--- soc_mem_top.sv
`timescale 1ns/1ps

module soc_mem_top import soc_mem_pkg::*; #(
    parameter int unsigned SRAM_DEPTH      = 256,
    parameter int unsigned MAX_OUTSTANDING = 4
) (
    input  logic      clk_i,
    input  logic      rst_n_i,

    // Wishbone host port
    input  logic      wbs_cyc_i,
    input  logic      wbs_stb_i,
    input  logic      wbs_we_i,
    input  obi_be_t   wbs_sel_i,
    input  obi_addr_t wbs_adr_i,
    input  obi_data_t wbs_dat_i,
    output logic      wbs_ack_o,
    output obi_data_t wbs_dat_o,

    // Core data port
    input  logic      core_req_i,
    input  obi_addr_t core_addr_i,
    input  logic      core_we_i,
    input  obi_be_t   core_be_i,
    input  obi_data_t core_wdata_i,
    output logic      core_gnt_o,
    output logic      core_rvalid_o,
    output obi_data_t core_rdata_o,

    // Control and status
    input  logic      host_en_i,
    output logic      illegal_access_o
);

    obi_if host_bus ();
    obi_if host_remapped ();
    obi_if core_bus ();
    obi_if mem_bus ();

    ////////////////////////////////////////////////////////////
    // Host path
    ////////////////////////////////////////////////////////////

    wb_obi_bridge u_wb_obi_bridge (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .wbs_cyc_i (wbs_cyc_i),
        .wbs_stb_i (wbs_stb_i),
        .wbs_we_i  (wbs_we_i),
        .wbs_sel_i (wbs_sel_i),
        .wbs_adr_i (wbs_adr_i),
        .wbs_dat_i (wbs_dat_i),
        .wbs_ack_o (wbs_ack_o),
        .wbs_dat_o (wbs_dat_o),
        .obi       (host_bus.primary)
    );

    host_addr_remap u_host_addr_remap (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .in      (host_bus.secondary),
        .out     (host_remapped.primary)
    );

    ////////////////////////////////////////////////////////////
    // Core port onto its bus
    ////////////////////////////////////////////////////////////

    assign core_bus.req   = core_req_i;
    assign core_bus.addr  = core_addr_i;
    assign core_bus.we    = core_we_i;
    assign core_bus.be    = core_be_i;
    assign core_bus.wdata = core_wdata_i;
    assign core_gnt_o     = core_bus.gnt;
    assign core_rvalid_o  = core_bus.rvalid;
    assign core_rdata_o   = core_bus.rdata;

    ////////////////////////////////////////////////////////////
    // Shared SRAM
    ////////////////////////////////////////////////////////////

    obi_arbiter #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_obi_arbiter (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .host_en_i (host_en_i),
        .host      (host_remapped.secondary),
        .core      (core_bus.secondary),
        .mem       (mem_bus.primary)
    );

    sram_bank #(
        .SRAM_DEPTH (SRAM_DEPTH)
    ) u_sram_bank (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .bus       (mem_bus.secondary),
        .illegal_o (illegal_access_o)
    );

endmodule

//--- sram_bank.sv
`timescale 1ns/1ps

module sram_bank import soc_mem_pkg::*; #(
    parameter int unsigned SRAM_DEPTH = 256
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    obi_if.secondary bus,
    output logic     illegal_o
);

    localparam int unsigned IDX_W = $clog2(SRAM_DEPTH);

    obi_data_t        mem_q [SRAM_DEPTH];
    obi_addr_t        word_idx;
    logic [IDX_W-1:0] idx;
    logic             legal;
    logic             rvalid_q;
    logic             illegal_q;
    obi_data_t        rdata_q;

    ////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////

    assign word_idx = (bus.addr & ~REGION_MASK) >> 2;
    assign idx      = word_idx[IDX_W-1:0];
    assign legal    = ((bus.addr & REGION_MASK) == SRAM_BASE) && (word_idx < SRAM_DEPTH);

    // Always ready
    assign bus.gnt = bus.req;

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (bus.req && bus.we && legal) begin
            for (int b = 0; b < $bits(obi_be_t); b++) begin
                if (bus.be[b]) begin
                    mem_q[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
        // Writes and illegal reads return zero
        rdata_q <= (bus.req && !bus.we && legal) ? mem_q[idx] : '0;
    end

    // Response one cycle after the grant
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rvalid_q  <= 1'b0;
            illegal_q <= 1'b0;
        end else begin
            rvalid_q  <= bus.req;
            illegal_q <= bus.req && !legal;
        end
    end

    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;
    assign illegal_o  = illegal_q;

endmodule

//--- obi_arbiter.sv
`timescale 1ns/1ps

module obi_arbiter #(
    parameter int unsigned MAX_OUTSTANDING = 4
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     host_en_i,
    obi_if.secondary host,
    obi_if.secondary core,
    obi_if.primary   mem
);

    localparam int unsigned PTR_W = (MAX_OUTSTANDING > 1) ? $clog2(MAX_OUTSTANDING) : 1;
    localparam int unsigned CNT_W = $clog2(MAX_OUTSTANDING + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(MAX_OUTSTANDING - 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(MAX_OUTSTANDING);

    // Owner per granted transfer, 1 means host
    logic             owner_q [MAX_OUTSTANDING];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             full;
    logic             host_sel;
    logic             push;
    logic             pop;
    logic             head_owner;

    ////////////////////////////////////////////////////////////
    // Request select
    ////////////////////////////////////////////////////////////

    assign full     = (count_q == CNT_FULL);
    assign host_sel = host.req && host_en_i;

    // Nothing goes out while the owner queue is full
    assign mem.req   = (host_sel || core.req) && !full;
    assign mem.addr  = host_sel ? host.addr  : core.addr;
    assign mem.we    = host_sel ? host.we    : core.we;
    assign mem.be    = host_sel ? host.be    : core.be;
    assign mem.wdata = host_sel ? host.wdata : core.wdata;

    assign host.gnt = host_sel && mem.gnt && !full;
    assign core.gnt = core.req && !host_sel && mem.gnt && !full;

    ////////////////////////////////////////////////////////////
    // Response routing
    ////////////////////////////////////////////////////////////

    assign push       = mem.req && mem.gnt;
    assign pop        = mem.rvalid;
    assign head_owner = owner_q[rd_ptr_q];

    assign host.rvalid = pop && head_owner;
    assign core.rvalid = pop && !head_owner;
    assign host.rdata  = mem.rdata;
    assign core.rdata  = mem.rdata;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            owner_q[wr_ptr_q] <= host_sel;
        end
    end

endmodule

//--- host_addr_remap.sv
`timescale 1ns/1ps

module host_addr_remap import soc_mem_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    obi_if.secondary in,
    obi_if.primary   out
);

    logic      full_q;
    logic      accept;
    obi_addr_t addr_mapped;
    obi_addr_t addr_q;
    logic      we_q;
    obi_be_t   be_q;
    obi_data_t wdata_q;

    ////////////////////////////////////////////////////////////
    // Address remap
    ////////////////////////////////////////////////////////////

    // Host window folds onto the SRAM region, offset kept
    always_comb begin
        addr_mapped = in.addr;
        if (in.addr >= HOST_WIN_LO && in.addr < HOST_WIN_HI) begin
            addr_mapped = (in.addr & ~REGION_MASK) | SRAM_BASE;
        end
    end

    ////////////////////////////////////////////////////////////
    // One-entry request register
    ////////////////////////////////////////////////////////////

    // Free slot, or the held request leaves this cycle
    assign in.gnt = !full_q || out.gnt;
    assign accept = in.req && in.gnt;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (accept) begin
            full_q <= 1'b1;
        end else if (out.gnt) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q  <= addr_mapped;
            we_q    <= in.we;
            be_q    <= in.be;
            wdata_q <= in.wdata;
        end
    end

    assign out.req   = full_q;
    assign out.addr  = addr_q;
    assign out.we    = we_q;
    assign out.be    = be_q;
    assign out.wdata = wdata_q;

    // Responses need no remap
    assign in.rvalid = out.rvalid;
    assign in.rdata  = out.rdata;

endmodule

//--- wb_obi_bridge.sv
`timescale 1ns/1ps

module wb_obi_bridge import soc_mem_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      wbs_cyc_i,
    input  logic      wbs_stb_i,
    input  logic      wbs_we_i,
    input  obi_be_t   wbs_sel_i,
    input  obi_addr_t wbs_adr_i,
    input  obi_data_t wbs_dat_i,
    output logic      wbs_ack_o,
    output obi_data_t wbs_dat_o,
    obi_if.primary    obi
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } state_e;

    state_e    state_q;
    obi_addr_t addr_q;
    logic      we_q;
    obi_be_t   be_q;
    obi_data_t wdata_q;
    logic      start;

    // Host still holds stb in the ack cycle, so skip that one
    assign start = wbs_cyc_i && wbs_stb_i && !wbs_ack_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= ST_IDLE;
            wbs_ack_o <= 1'b0;
        end else begin
            wbs_ack_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (obi.gnt) begin
                        state_q <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (obi.rvalid) begin
                        state_q   <= ST_IDLE;
                        wbs_ack_o <= 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Captured request and returned read word
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && start) begin
            addr_q  <= wbs_adr_i;
            we_q    <= wbs_we_i;
            be_q    <= wbs_sel_i;
            wdata_q <= wbs_dat_i;
        end
        if (state_q == ST_WAIT && obi.rvalid) begin
            wbs_dat_o <= obi.rdata;
        end
    end

    assign obi.req   = (state_q == ST_REQ);
    assign obi.addr  = addr_q;
    assign obi.we    = we_q;
    assign obi.be    = be_q;
    assign obi.wdata = wdata_q;

endmodule

//--- obi_if.sv
`timescale 1ns/1ps

interface obi_if;

    // Request side, driven by the primary
    logic                   req;
    soc_mem_pkg::obi_addr_t addr;
    logic                   we;
    soc_mem_pkg::obi_be_t   be;
    soc_mem_pkg::obi_data_t wdata;

    // Grant and response, driven by the secondary
    logic                   gnt;
    logic                   rvalid;
    soc_mem_pkg::obi_data_t rdata;

    modport primary (
        output req,
        output addr,
        output we,
        output be,
        output wdata,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    modport secondary (
        input  req,
        input  addr,
        input  we,
        input  be,
        input  wdata,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

//--- soc_mem_pkg.sv
package soc_mem_pkg;

    ////////////////////////////////////////////////////////////
    // Bus types
    ////////////////////////////////////////////////////////////

    // Byte address, word data and per-byte enables
    typedef logic [31:0] obi_addr_t;
    typedef logic [31:0] obi_data_t;
    typedef logic [3:0]  obi_be_t;

    ////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////

    // Host window, upper bound exclusive
    localparam obi_addr_t HOST_WIN_LO = 32'h3000_0000;
    localparam obi_addr_t HOST_WIN_HI = 32'h8000_0000;

    // Data SRAM region
    localparam obi_addr_t SRAM_BASE   = 32'h8000_0000;

    // Upper nibble picks the region
    localparam obi_addr_t REGION_MASK = 32'hF000_0000;

endpackage
